/* logic/video_pkg.sv */
// shared video fetch types and timing constants, referenced by scoped name from every module
package video_pkg;

	// graphics mode, render mode is the same encoding
	typedef enum logic [1:0] {
		MODE_ZX = 2'd0,    // zx screen
		MODE_HC = 2'd1,    // 16 colour
		MODE_XC = 2'd2,    // 256 colour
		MODE_TX = 2'd3     // text
	} vmode_e;

	// who owns a dram request
	typedef enum logic [1:0] {
		SRC_GFX   = 2'd0,
		SRC_TILE0 = 2'd1,
		SRC_TILE1 = 2'd2
	} req_src_e;

	// cpu registers as latched at line start
	typedef struct packed {
		vmode_e     mode;
		logic [1:0] rres;       // raster resolution select
		logic       nogfx;      // graphics fetch off
		logic [8:0] gx_offs;
		logic [7:0] vpage;
		logic [7:0] tmpage;     // tilemap page
		logic [1:0] tm_en;      // per plane enable
		logic [5:0] t0y_offs;
		logic [5:0] t1y_offs;
	} vcfg_t;

	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic [7:0] cnt_col;
		logic [8:0] cnt_row;
		logic [8:0] cnt_tp_row; // same as vcnt
		logic [2:0] tp_slot;
		logic [2:0] tp_phase;
		logic       in_prefetch;
	} raster_pos_t;

	typedef struct packed {
		logic [8:0] hpix_beg;
		logic [8:0] hpix_end;
		logic [8:0] vpix_beg;
		logic [8:0] vpix_end;
		logic [5:0] x_tiles;
		logic [9:0] x_offs_mode;
		logic [4:0] video_bw;
		logic       tv_hires;
	} mode_params_t;

	typedef struct packed {
		logic        stb;
		logic [20:0] addr;
		logic [8:0]  waddr;     // tile buffer slot
	} tile_req_t;

	typedef struct packed {
		logic        stb;
		logic [20:0] addr;
		logic [4:0]  bw;
		req_src_e    src;
		logic [8:0]  waddr;
	} video_req_t;

	localparam int H_TOTAL     = 448;   // clocks per line
	localparam int V_TOTAL     = 320;   // lines per frame
	localparam int TP_SLOTS    = 8;
	localparam int TP_SLOT_LEN = 8;
	localparam int N_PLANES    = 2;

	// resolution tables, index is rres: 256x192, 320x240, 320x240, 360x288
	localparam logic [8:0] HP_BEG [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
	localparam logic [8:0] HP_END [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
	localparam logic [8:0] VP_BEG [4] = '{9'd80, 9'd56, 9'd56, 9'd32};
	localparam logic [8:0] VP_END [4] = '{9'd272, 9'd296, 9'd296, 9'd320};
	localparam logic [5:0] X_TILE [4] = '{6'd33, 6'd41, 6'd41, 6'd46};

	// bandwidth: [4:3] total cycles, [2:0] needed cycles
	localparam logic [1:0] BWT_2 = 2'b00;
	localparam logic [1:0] BWT_4 = 2'b01;
	localparam logic [1:0] BWT_8 = 2'b11;
	localparam logic [4:0] BW_ZX    = {BWT_8, 3'b001};  // 1 of 8
	localparam logic [4:0] BW_HC    = {BWT_4, 3'b001};  // 1 of 4
	localparam logic [4:0] BW_XC    = {BWT_2, 3'b001};  // 1 of 2
	localparam logic [4:0] BW_TX    = {BWT_8, 3'b100};  // 4 of 8
	localparam logic [4:0] BW_TILE1 = {BWT_8, 3'b010};  // one plane on
	localparam logic [4:0] BW_TILE2 = {BWT_8, 3'b100};  // both planes on

endpackage

/* logic/raster_counter.sv */
// raster timing: line and frame counters, fetch cadence and column counters, prefetch slots
`timescale 1ns/1ps

module raster_counter (
	input  logic                     clk,
	input  logic                     arst_n,
	input  video_pkg::mode_params_t  params,      // latched mode parameters
	input  logic                     gfx_stb,     // column advances on each fetch
	output video_pkg::raster_pos_t   pos,
	output logic                     line_start,
	output logic [3:0]               fetch_cnt
);

	logic [8:0] hcnt;
	logic [8:0] vcnt;
	logic [7:0] cnt_col;
	logic       line_end;
	logic       frame_end;
	logic       pix_pre;    // clock before the pixel window opens

	assign line_end   = (hcnt == 9'(video_pkg::H_TOTAL - 1));
	assign frame_end  = (vcnt == 9'(video_pkg::V_TOTAL - 1));
	assign pix_pre    = (hcnt == params.hpix_beg - 9'd1);
	assign line_start = (hcnt == 9'd0);  // exactly one clock per line

	// line and frame position
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (line_end)
		begin
			hcnt <= '0;
			vcnt <= frame_end ? 9'd0 : vcnt + 9'd1;  // wrap after last line
		end
		else
			hcnt <= hcnt + 9'd1;
	end

	// cadence and column, both zero when hcnt reaches hpix_beg
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fetch_cnt <= '0;
			cnt_col   <= '0;
		end
		else if (pix_pre)
		begin
			fetch_cnt <= '0;
			cnt_col   <= '0;
		end
		else
		begin
			fetch_cnt <= fetch_cnt + 4'd1;  // free running, low bits pick the rate
			if (gfx_stb)
				cnt_col <= cnt_col + 8'd1;
		end
	end

	always_comb
	begin
		pos.hcnt        = hcnt;
		pos.vcnt        = vcnt;
		pos.cnt_col     = cnt_col;
		pos.cnt_row     = vcnt - params.vpix_beg;       // row inside the pixel window
		pos.cnt_tp_row  = vcnt;                          // tiles count from line 0
		pos.tp_slot     = 3'(hcnt / 9'(video_pkg::TP_SLOT_LEN));
		pos.tp_phase    = 3'(hcnt % 9'(video_pkg::TP_SLOT_LEN));
		pos.in_prefetch = (hcnt < 9'(video_pkg::TP_SLOTS * video_pkg::TP_SLOT_LEN));
	end

endmodule

/* logic/video_mode.sv */
// video mode decoder: latches config per line, decodes resolution and bandwidth, makes gfx fetch requests
`timescale 1ns/1ps

module video_mode (
	input  logic                     clk,
	input  logic                     arst_n,
	input  video_pkg::vcfg_t         video_config,  // live cpu registers
	input  logic                     vpage_wr,
	input  logic                     line_start,
	input  video_pkg::raster_pos_t   pos,
	input  logic [3:0]               fetch_cnt,
	input  logic [15:0]              txt_char,      // two char codes for glyph fetch
	output video_pkg::vcfg_t         cfg_d,
	output video_pkg::mode_params_t  params,
	output video_pkg::video_req_t    gfx_req
);

	logic        vpage_wr_r;
	logic        in_hwin;
	logic        in_vwin;
	logic        cadence;
	logic        gfx_stb;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [13:0] addr_tx;
	logic [20:0] gfx_addr;

	// whole config at line start, vpage alone one clock after a cpu write
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cfg_d      <= '0;    // zx mode
			vpage_wr_r <= 1'b0;
		end
		else
		begin
			vpage_wr_r <= vpage_wr;
			if (line_start)
				cfg_d <= video_config;
			else if (vpage_wr_r)
				cfg_d.vpage <= video_config.vpage;
		end
	end

	// mode and resolution decode
	always_comb
	begin
		params.hpix_beg = video_pkg::HP_BEG[cfg_d.rres];
		params.hpix_end = video_pkg::HP_END[cfg_d.rres];
		params.vpix_beg = video_pkg::VP_BEG[cfg_d.rres];
		params.vpix_end = video_pkg::VP_END[cfg_d.rres];
		params.x_tiles  = video_pkg::X_TILE[cfg_d.rres];
		// 256c scrolls in whole pixels, others in half
		if (cfg_d.mode == video_pkg::MODE_XC)
			params.x_offs_mode = {cfg_d.gx_offs[8:1], 1'b0, cfg_d.gx_offs[0]};
		else
			params.x_offs_mode = {1'b0, cfg_d.gx_offs[8:1], cfg_d.gx_offs[0]};
		case (cfg_d.mode)
			video_pkg::MODE_ZX: params.video_bw = video_pkg::BW_ZX;
			video_pkg::MODE_HC: params.video_bw = video_pkg::BW_HC;
			video_pkg::MODE_XC: params.video_bw = video_pkg::BW_XC;
			default:            params.video_bw = video_pkg::BW_TX;
		endcase
		params.tv_hires = (cfg_d.mode == video_pkg::MODE_TX);  // text runs double rate
	end

	// fetch window and cadence
	assign in_hwin = (pos.hcnt >= params.hpix_beg) && (pos.hcnt < params.hpix_end);
	assign in_vwin = (pos.vcnt >= params.vpix_beg) && (pos.vcnt < params.vpix_end);

	always_comb
	begin
		case (cfg_d.mode)
			video_pkg::MODE_HC: cadence = &fetch_cnt[1:0];  // every 4 clocks
			video_pkg::MODE_XC: cadence = fetch_cnt[0];     // every 2
			default:            cadence = &fetch_cnt;       // zx and text every 16
		endcase
	end

	assign gfx_stb = in_hwin && in_vwin && !cfg_d.nogfx && cadence;

	// zx screen layout, thirds then char lines
	assign addr_zx_gfx = {pos.cnt_row[7:6], pos.cnt_row[2:0], pos.cnt_row[5:3], pos.cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, pos.cnt_row[7:3], pos.cnt_col[4:1]};

	// text: char, attr, then glyph lines for both chars
	always_comb
	begin
		case (pos.cnt_col[1:0])
			2'd0:    addr_tx = {cfg_d.vpage[0], pos.cnt_row[8:3], 1'b0, pos.cnt_col[7:2]};
			2'd1:    addr_tx = {cfg_d.vpage[0], pos.cnt_row[8:3], 1'b1, pos.cnt_col[7:2]};
			2'd2:    addr_tx = {~cfg_d.vpage[0], 3'b000, txt_char[7:0], pos.cnt_row[2:1]};
			default: addr_tx = {~cfg_d.vpage[0], 3'b000, txt_char[15:8], pos.cnt_row[2:1]};
		endcase
	end

	always_comb
	begin
		case (cfg_d.mode)
			video_pkg::MODE_ZX:
				gfx_addr = {cfg_d.vpage, 1'b0, pos.cnt_col[0] ? addr_zx_atr : addr_zx_gfx};
			video_pkg::MODE_HC:
				gfx_addr = {cfg_d.vpage[7:3], pos.cnt_row, pos.cnt_col[6:0]};
			video_pkg::MODE_XC:
				gfx_addr = {cfg_d.vpage[7:4], pos.cnt_row, pos.cnt_col};
			default:
				gfx_addr = {cfg_d.vpage[7:1], addr_tx};
		endcase
	end

	always_comb
	begin
		gfx_req.stb   = gfx_stb;
		gfx_req.addr  = gfx_addr;
		gfx_req.bw    = params.video_bw;
		gfx_req.src   = video_pkg::SRC_GFX;
		gfx_req.waddr = '0;  // gfx data bypasses tile buffer
	end

endmodule

/* logic/tile_plane_fetch.sv */
// tilemap prefetch address and tile buffer write address for one plane, one instance per plane
`timescale 1ns/1ps

module tile_plane_fetch #(
	parameter int PLANE = 0  // 0 or 1
) (
	input  video_pkg::vcfg_t        cfg_d,
	input  video_pkg::raster_pos_t  pos,
	output video_pkg::tile_req_t    req
);

	localparam logic PBIT = 1'(PLANE);

	logic [5:0] y_offs;
	logic [5:0] tpos_y;
	logic [5:0] tpos_x;
	logic       slot_hit;

	// per plane y scroll from config only
	assign y_offs = PBIT ? cfg_d.t1y_offs : cfg_d.t0y_offs;
	assign tpos_y = pos.cnt_tp_row[8:3] + y_offs;       // tile row, wraps at 64
	assign tpos_x = {pos.cnt_tp_row[2:0], pos.tp_slot};  // 64 tiles over 8 lines

	// own phase of each slot, only while enabled
	assign slot_hit = pos.in_prefetch && (pos.tp_phase == 3'(PLANE)) && cfg_d.tm_en[PLANE];

	always_comb
	begin
		req.stb   = slot_hit;
		req.addr  = {cfg_d.tmpage, tpos_y, PBIT, tpos_x};          // 128 bytes per plane
		req.waddr = {pos.cnt_tp_row[4:0], pos.tp_slot, PBIT};     // one word per plane
	end

endmodule

/* logic/video_addr_arbiter.sv */
// merges tile plane and graphics requests into one registered dram request per clock
`timescale 1ns/1ps

module video_addr_arbiter (
	input  logic                   clk,
	input  logic                   arst_n,
	input  video_pkg::video_req_t  gfx_req,
	input  video_pkg::tile_req_t   tile_reqs [video_pkg::N_PLANES],
	input  video_pkg::vcfg_t       cfg_d,
	output video_pkg::video_req_t  video_req
);

	logic [4:0]            tile_bw;
	video_pkg::video_req_t nxt;

	// tile cost depends on how many planes share the prefetch
	assign tile_bw = (&cfg_d.tm_en) ? video_pkg::BW_TILE2 : video_pkg::BW_TILE1;

	// windows never overlap, priority only breaks ties
	always_comb
	begin
		nxt = gfx_req;  // lowest priority
		for (int p = video_pkg::N_PLANES - 1; p >= 0; p--)
		begin
			if (tile_reqs[p].stb)
			begin
				nxt.stb   = 1'b1;
				nxt.addr  = tile_reqs[p].addr;
				nxt.bw    = tile_bw;
				nxt.src   = video_pkg::req_src_e'(p + 1);  // plane 0 wins, checked last
				nxt.waddr = tile_reqs[p].waddr;
			end
		end
	end

	// one clock after the source strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			video_req <= '0;
		else
			video_req <= nxt;
	end

endmodule

/* logic/video_fetch_top.sv */
// video fetch top: raster counter, mode decoder, tile planes and dram request arbiter
`timescale 1ns/1ps

module video_fetch_top (
	input  logic                     clk,
	input  logic                     arst_n,
	input  video_pkg::vcfg_t         video_config,
	input  logic                     vpage_wr,
	input  logic [15:0]              txt_char,
	output video_pkg::video_req_t    video_req,
	output video_pkg::mode_params_t  params,
	output logic                     line_start
);

	video_pkg::vcfg_t       cfg_d;
	video_pkg::raster_pos_t pos;
	video_pkg::video_req_t  gfx_req;
	video_pkg::tile_req_t   tile_reqs [video_pkg::N_PLANES];
	logic [3:0]             fetch_cnt;

	raster_counter raster_counter_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.params     (params),
		.gfx_stb    (gfx_req.stb),
		.pos        (pos),
		.line_start (line_start),
		.fetch_cnt  (fetch_cnt)
	);

	video_mode video_mode_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.video_config (video_config),
		.vpage_wr     (vpage_wr),
		.line_start   (line_start),
		.pos          (pos),
		.fetch_cnt    (fetch_cnt),
		.txt_char     (txt_char),
		.cfg_d        (cfg_d),
		.params       (params),
		.gfx_req      (gfx_req)
	);

	// one prefetch unit per tile plane
	for (genvar p = 0; p < video_pkg::N_PLANES; p++)
	begin : g_plane
		tile_plane_fetch #(
			.PLANE (p)
		) tile_plane_fetch_inst (
			.cfg_d (cfg_d),
			.pos   (pos),
			.req   (tile_reqs[p])
		);
	end

	video_addr_arbiter video_addr_arbiter_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.gfx_req   (gfx_req),
		.tile_reqs (tile_reqs),
		.cfg_d     (cfg_d),
		.video_req (video_req)
	);

endmodule

/* verification/video_fetch_tb.sv */
// video fetch top testbench that drives config and checks every dram request against a model
`timescale 1ns/1ps

module video_fetch_tb;

	localparam int TEST_COUNT = 5;
	localparam int TIMEOUT_CYCLES = TEST_COUNT * 3 * video_pkg::H_TOTAL * video_pkg::V_TOTAL;
	localparam logic [8:0] H_LAST = 9'(video_pkg::H_TOTAL - 1);
	localparam logic [8:0] V_LAST = 9'(video_pkg::V_TOTAL - 1);

	logic                    clk;
	logic                    arst_n;
	video_pkg::vcfg_t        video_config;
	logic                    vpage_wr;
	logic [15:0]             txt_char;
	video_pkg::video_req_t   video_req;
	video_pkg::mode_params_t params;
	logic                    line_start;

	video_pkg::vcfg_t        cfg;       // stimulus copy
	video_pkg::vcfg_t        mcfg;      // config the dut should hold
	video_pkg::video_req_t   exp_req;   // expected register contents next clock
	logic [8:0] mh;                     // mirror of hcnt
	logic [8:0] mv;                     // mirror of vcnt
	logic [7:0] mcol;
	logic       wr_d;
	logic       synced;
	int errors, test_base, tests, failed, gfx_seen, tile_seen, n_on, cycles;

	video_fetch_top video_fetch_top_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.video_config (video_config),
		.vpage_wr     (vpage_wr),
		.txt_char     (txt_char),
		.video_req    (video_req),
		.params       (params),
		.line_start   (line_start)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns
	end

	// [4:3] total cycles 8=11 4=01 2=00, [2:0] cycles used
	function automatic logic [4:0] bw_code(input video_pkg::vmode_e m);
		case (m)
			video_pkg::MODE_ZX: return 5'b11_001;
			video_pkg::MODE_HC: return 5'b01_001;
			video_pkg::MODE_XC: return 5'b00_001;
			default:            return 5'b11_100;
		endcase
	endfunction

	function automatic video_pkg::mode_params_t res_params(input video_pkg::vcfg_t c);
		logic [8:0] hb [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
		logic [8:0] he [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
		logic [8:0] vb [4] = '{9'd80, 9'd56, 9'd56, 9'd32};
		logic [8:0] ve [4] = '{9'd272, 9'd296, 9'd296, 9'd320};
		logic [5:0] xt [4] = '{6'd33, 6'd41, 6'd41, 6'd46};
		video_pkg::mode_params_t p;
		p          = '0;
		p.hpix_beg = hb[c.rres];
		p.hpix_end = he[c.rres];
		p.vpix_beg = vb[c.rres];
		p.vpix_end = ve[c.rres];
		p.x_tiles  = xt[c.rres];
		// 256c offset steps twice as far
		if (c.mode == video_pkg::MODE_XC)
			p.x_offs_mode = {c.gx_offs[8:1], 2'b00} | 10'(c.gx_offs[0]);
		else
			p.x_offs_mode = 10'(c.gx_offs);
		p.video_bw = bw_code(c.mode);
		p.tv_hires = (c.mode == video_pkg::MODE_TX);
		return p;
	endfunction

	// d counts clocks since hpix_beg
	function automatic logic fetch_due(input video_pkg::vmode_e m, input logic [8:0] d);
		case (m)
			video_pkg::MODE_HC: return d[1:0] == 2'b11;
			video_pkg::MODE_XC: return d[0];
			default:            return d[3:0] == 4'hf;
		endcase
	endfunction

	function automatic logic [20:0] gfx_addr_for(input video_pkg::vcfg_t c, input logic [8:0] row,
		input logic [7:0] col, input logic [15:0] tc);
		case (c.mode)
			video_pkg::MODE_ZX:
				return {c.vpage, 1'b0, col[0] ? {3'b110, row[7:3], col[4:1]}
					: {row[7:6], row[2:0], row[5:3], col[4:1]}};  // odd col is attribute
			video_pkg::MODE_HC:
				return {c.vpage[7:3], row, col[6:0]};
			video_pkg::MODE_XC:
				return {c.vpage[7:4], row, col};
			default:
			begin
				case (col[1:0])  // char, attr, glyph lo, glyph hi
					2'd0:    return {c.vpage, row[8:3], 1'b0, col[7:2]};
					2'd1:    return {c.vpage, row[8:3], 1'b1, col[7:2]};
					2'd2:    return {c.vpage[7:1], ~c.vpage[0], 3'b000, tc[7:0], row[2:1]};
					default: return {c.vpage[7:1], ~c.vpage[0], 3'b000, tc[15:8], row[2:1]};
				endcase
			end
		endcase
	endfunction

	function automatic logic [20:0] tile_addr_for(input video_pkg::vcfg_t c, input logic pb,
		input logic [8:0] v, input logic [2:0] slot);
		logic [5:0] ty;
		ty = v[8:3] + (pb ? c.t1y_offs : c.t0y_offs);  // wraps at 64 rows
		return {c.tmpage, ty, pb, v[2:0], slot};
	endfunction

	task automatic flag_mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
		errors++;
		$display("Fail %s: got %h expected %h (line %0d hcnt %0d)", name, got, exp, mv, mh);
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("error: %s (line %0d hcnt %0d)", msg, mv, mh);
	endtask

	// compare on the falling edge, model the next clock
	always @(negedge clk)
	begin : compare_proc
		video_pkg::mode_params_t rp;
		video_pkg::video_req_t   nxt;
		logic [8:0]              dh;
		if (!arst_n)
		begin
			if (video_req.stb)
				note_failure("request strobe during reset");
			mcfg    = '0;
			exp_req = '0;
			wr_d    = 1'b0;
			mcol    = '0;
			synced  = 1'b0;
			mh      = '0;
			mv      = '0;
		end
		else
		begin
			if (synced)
			begin
				mv = (mh == H_LAST) ? ((mv == V_LAST) ? 9'd0 : mv + 9'd1) : mv;
				mh = (mh == H_LAST) ? 9'd0 : mh + 9'd1;
			end
			synced = 1'b1;  // first clock after reset is hcnt 0
			if (line_start !== (mh == 9'd0))
				flag_mismatch("line_start", 64'(line_start), 64'(mh == 9'd0));
			if (video_req.stb !== exp_req.stb)
				flag_mismatch("video_req.stb", 64'(video_req.stb), 64'(exp_req.stb));
			else if (exp_req.stb)
			begin
				if (video_req.addr !== exp_req.addr)
					flag_mismatch("video_req.addr", 64'(video_req.addr), 64'(exp_req.addr));
				if (video_req.bw !== exp_req.bw)
					flag_mismatch("video_req.bw", 64'(video_req.bw), 64'(exp_req.bw));
				if (video_req.src !== exp_req.src)
					flag_mismatch("video_req.src", 64'(video_req.src), 64'(exp_req.src));
				if (exp_req.src != video_pkg::SRC_GFX && video_req.waddr !== exp_req.waddr)
					flag_mismatch("video_req.waddr", 64'(video_req.waddr), 64'(exp_req.waddr));
			end
			if (video_req.stb && video_req.src == video_pkg::SRC_GFX)
				gfx_seen++;
			else if (video_req.stb)
				tile_seen++;
			rp = res_params(mcfg);
			if ({params.hpix_beg, params.hpix_end, params.vpix_beg, params.vpix_end,
				params.x_tiles} !== {rp.hpix_beg, rp.hpix_end, rp.vpix_beg, rp.vpix_end, rp.x_tiles})
				flag_mismatch("params.window", 64'({params.hpix_beg, params.hpix_end,
					params.vpix_beg, params.vpix_end, params.x_tiles}), 64'({rp.hpix_beg,
					rp.hpix_end, rp.vpix_beg, rp.vpix_end, rp.x_tiles}));
			if (params.x_offs_mode !== rp.x_offs_mode)
				flag_mismatch("params.x_offs_mode", 64'(params.x_offs_mode), 64'(rp.x_offs_mode));
			if (params.video_bw !== rp.video_bw)
				flag_mismatch("params.video_bw", 64'(params.video_bw), 64'(rp.video_bw));
			if (params.tv_hires !== rp.tv_hires)
				flag_mismatch("params.tv_hires", 64'(params.tv_hires), 64'(rp.tv_hires));
			nxt = '0;
			if (mh == rp.hpix_beg)
				mcol = '0;
			dh = mh - rp.hpix_beg;
			if (mh < 9'd64 && mh[2:1] == 2'b00 && mcfg.tm_en[mh[0]])  // phase 0 and 1 of a slot
			begin
				nxt.stb   = 1'b1;
				nxt.addr  = tile_addr_for(mcfg, mh[0], mv, mh[5:3]);
				nxt.waddr = {mv[4:0], mh[5:3], mh[0]};
				nxt.bw    = (&mcfg.tm_en) ? 5'b11_100 : 5'b11_010;
				nxt.src   = mh[0] ? video_pkg::SRC_TILE1 : video_pkg::SRC_TILE0;
			end
			else if (mh >= rp.hpix_beg && mh < rp.hpix_end && mv >= rp.vpix_beg
				&& mv < rp.vpix_end && !mcfg.nogfx && fetch_due(mcfg.mode, dh))
			begin
				nxt.stb  = 1'b1;
				nxt.addr = gfx_addr_for(mcfg, mv - rp.vpix_beg, mcol, txt_char);
				nxt.bw   = bw_code(mcfg.mode);
				nxt.src  = video_pkg::SRC_GFX;
				mcol     = mcol + 8'd1;
			end
			exp_req = nxt;
			if (mh == 9'd0)
				mcfg = video_config;  // whole config at line start
			else if (wr_d)
				mcfg.vpage = video_config.vpage;
			wr_d = vpage_wr;
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
		txt_char = 16'($urandom);  // fresh char codes every clock
	endtask

	// returns in the clock after hcnt h, on line v or any line when v is negative
	task automatic wait_hcnt(input logic [8:0] h, input int v);
		do
			step();
		while (!(mh == h && (v < 0 || mv == 9'(v))));
	endtask

	task automatic wait_lines(input int n);
		repeat (n) wait_hcnt(9'd0, -1);
	endtask

	task automatic start_test();
		test_base = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_base)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			failed++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_base);
		end
	endtask

	initial
	begin
		void'($urandom(32'hbb84_24e1));
		arst_n       = 1'b0;
		video_config = '0;
		vpage_wr     = 1'b0;
		txt_char     = '0;
		errors       = 0;
		tests        = 0;
		failed       = 0;
		gfx_seen     = 0;
		tile_seen    = 0;
		repeat (16) @(posedge clk);
		#1 arst_n = 1'b1;

		start_test();
		wait_lines(3);  // strobes and line period checked every clock
		end_test("reset quiet");

		start_test();
		cfg = '0;
		for (int r = 0; r < 4; r++)
		begin
			wait_hcnt(9'd200, -1);
			cfg.rres     = 2'(r);
			video_config = cfg;  // params must hold until next line start
			wait_lines(2);
		end
		end_test("resolution decode");

		start_test();
		wait_hcnt(9'd100, video_pkg::V_TOTAL - 1);
		for (int m = 0; m < 5; m++)
		begin
			cfg.mode     = video_pkg::vmode_e'(m[1:0]);
			cfg.rres     = 2'($urandom);
			cfg.vpage    = 8'($urandom);
			cfg.gx_offs  = 9'($urandom);
			cfg.nogfx    = (m == 4);  // last pass zx with fetch off
			video_config = cfg;
			wait_lines(1);
			gfx_seen = 0;
			wait_hcnt(9'd100, video_pkg::V_TOTAL - 1);
			if (m < 4 && gfx_seen == 0)
				note_failure($sformatf("no graphics requests in a frame of mode %0d", m));
			if (m == 4 && gfx_seen != 0)
				note_failure("graphics requests while nogfx is set");
		end
		end_test("graphics addresses");

		start_test();
		for (int t = 0; t < 4; t++)
		begin
			cfg.nogfx    = 1'b0;
			cfg.tm_en    = 2'(t);
			cfg.tmpage   = 8'($urandom);
			cfg.t0y_offs = 6'($urandom);
			cfg.t1y_offs = 6'($urandom);
			video_config = cfg;
			wait_lines(2);  // count from the first line that starts with the new config
			tile_seen = 0;
			n_on = int'(cfg.tm_en[0]) + int'(cfg.tm_en[1]);
			wait_lines(12);
			if (tile_seen != 12 * video_pkg::TP_SLOTS * n_on)
				note_failure($sformatf("%0d tile requests over 12 lines with tm_en %0d", tile_seen, t));
		end
		end_test("tile prefetch");

		start_test();
		cfg.mode     = video_pkg::MODE_XC;
		cfg.rres     = 2'd1;
		cfg.tm_en    = 2'b11;
		video_config = cfg;
		wait_hcnt(9'd200, 100);  // inside the pixel window
		cfg.mode     = video_pkg::MODE_HC;
		cfg.vpage    = 8'($urandom);
		cfg.tm_en    = 2'b01;
		cfg.t0y_offs = 6'($urandom);
		video_config = cfg;      // mid-line change waits for next line start
		wait_hcnt(9'd250, 101);
		video_config.vpage = 8'($urandom);
		vpage_wr = 1'b1;
		step();
		vpage_wr = 1'b0;
		wait_lines(2);
		end_test("line-stable config");

		$display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// ends the run after three frames per test
	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* project.f */
logic/video_pkg.sv
logic/raster_counter.sv
logic/video_mode.sv
logic/tile_plane_fetch.sv
logic/video_addr_arbiter.sv
logic/video_fetch_top.sv
verification/video_fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the video fetch testbench with verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module video_fetch_tb \
	-f project.f -Mdir obj_dir -o video_fetch_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/video_fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* PASS \*\*' "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see $LOG"
exit 1
